// File: Makefile
VERILATOR ?= verilator
TOP       ?= rename_unit_tb
FILELIST  ?= rename_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/rename_unit_tb.sv
/*
  Testbench for rename_unit with a queue-based reference model. Retires follow
  allocation order and writeback targets the current speculative mapping.
*/
`timescale 1ns/1ps

module rename_unit_tb;
  import rename_pkg::*;

  localparam int RENAME_WIDTH = 2;
  localparam int COMMIT_WIDTH = 2;
  localparam int WAIT_LIMIT   = 20;

  // One cycle of stimulus, exp_prd is slot 0's prd one cycle later (0 skips)
  typedef struct packed {
    rename_req_t [RENAME_WIDTH-1:0] req;
    logic        [1:0]              ret_n;
    arf_idx_t    [COMMIT_WIDTH-1:0] wb_arf;
    logic                           stall;
    logic                           recover;
    prf_idx_t                       exp_prd;
  } row_t;

  logic                            clock;
  logic                            reset;
  logic                            stall;
  logic                            recover;
  rename_req_t  [RENAME_WIDTH-1:0] req;
  retire_t      [COMMIT_WIDTH-1:0] retire;
  logic         [COMMIT_WIDTH-1:0] wb_valid;
  prf_idx_t     [COMMIT_WIDTH-1:0] wb_prf;
  renamed_uop_t [RENAME_WIDTH-1:0] uop_out;
  logic                            allocatable;

  // Reference model
  prf_idx_t                        spec_map   [ARF_SIZE];
  prf_idx_t                        commit_map [ARF_SIZE];
  prf_idx_t                        free_q     [$];
  retire_t                         inflight_q [$];
  logic         [PRF_SIZE-1:0]     busy_m;
  renamed_uop_t [RENAME_WIDTH-1:0] exp_uop;
  row_t                            table_q    [$];
  prf_idx_t                        pending_prd;
  logic         [15:0]             lfsr_state;

  rename_unit #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) DUT (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .recover     (recover),
    .req         (req),
    .retire      (retire),
    .wb_valid    (wb_valid),
    .wb_prf      (wb_prf),
    .uop_out     (uop_out),
    .allocatable (allocatable)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic arf_idx_t rand_bits(int n);
    arf_idx_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[3:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string name, prf_idx_t got, prf_idx_t expected);
    assert (got === expected) else begin
      $display("ERR %s got %h exp %h", name, got, expected);
      stop_on_error();
    end
  endtask

  task automatic add_row(input arf_idx_t a1, a2, ad, b1, b2, bd, input logic [1:0] ret_n,
                         input arf_idx_t wa, wb, input logic st, rc, input prf_idx_t ep);
    row_t r;
    r           = '0;
    r.req[0]    = '{valid: 1'b1, rs1: a1, rs2: a2, rd: ad, rd_valid: 1'b1};
    r.req[1]    = '{valid: 1'b1, rs1: b1, rs2: b2, rd: bd, rd_valid: 1'b1};
    r.ret_n     = ret_n;
    r.wb_arf[0] = wa;
    r.wb_arf[1] = wb;
    r.stall     = st;
    r.recover   = rc;
    r.exp_prd   = ep;
    table_q.push_back(r);
  endtask

  task automatic add_random_row();
    row_t r;
    r = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      r.req[i].valid    = 1'b1;
      r.req[i].rd_valid = 1'b1;
      r.req[i].rs1      = rand_bits(5);
      r.req[i].rs2      = rand_bits(5);
      r.req[i].rd       = rand_bits(5);
    end
    r.ret_n     = 2'(rand_bits(1));
    r.wb_arf[0] = rand_bits(5);
    table_q.push_back(r);
  endtask

  task automatic build_table();
    // Reset map, forwarding inside a group, x0 and busy bits
    add_row(1, 2, 3, 3, 4, 0, 0, 0, 0, 0, 0, 32);
    add_row(5, 0, 5, 5, 3, 5, 0, 0, 0, 0, 0, 33);
    add_row(5, 3, 6, 6, 0, 7, 0, 0, 0, 0, 0, 35);
    add_row(5, 3, 0, 7, 1, 0, 0, 5, 3, 0, 0, 0);
    add_row(5, 3, 8, 0, 0, 0, 0, 0, 0, 0, 0, 37);
    add_row(9, 9, 9, 10, 10, 10, 0, 0, 0, 1, 0, 0);
    add_row(9, 9, 9, 10, 10, 10, 0, 0, 0, 1, 0, 0);
    add_row(9, 10, 9, 9, 0, 10, 0, 0, 0, 0, 0, 38);
    add_row(0, 0, 0, 0, 0, 0, 2, 0, 0, 0, 0, 0);
    for (int i = 0; i < 8; i++) begin
      add_random_row();
    end
    // Enough groups to drain the free list
    for (int i = 0; i < 20; i++) begin
      add_row(arf_idx_t'(i + 1), 3, arf_idx_t'(i + 1), arf_idx_t'(i + 1), 4,
              arf_idx_t'(i + 11), 0, 0, 0, 0, 0, 0);
    end
    for (int i = 0; i < 4; i++) begin
      add_row(1, 2, arf_idx_t'(i + 20), 3, 4, arf_idx_t'(i + 24), 2, 0, 0, 0, 0, 0);
    end
    add_row(1, 2, 13, 3, 4, 14, 1, 0, 0, 0, 1, 0);
    for (int i = 0; i < 8; i++) begin
      add_row(arf_idx_t'(4 * i + 1), arf_idx_t'(4 * i + 2), arf_idx_t'(4 * i + 3),
              arf_idx_t'(4 * i + 3), arf_idx_t'(4 * i + 4), 0, 1,
              arf_idx_t'(4 * i + 2), 0, 0, 0, 0);
    end
    for (int i = 0; i < 8; i++) begin
      add_random_row();
    end
    // Idle groups flush the last results
    add_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
  endtask

  task automatic apply_row(row_t r);
    retire_t  [COMMIT_WIDTH-1:0] ret_v;
    logic     [COMMIT_WIDTH-1:0] wb_v;
    prf_idx_t [COMMIT_WIDTH-1:0] wbp_v;
    ret_v = '0;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      if (i < int'(r.ret_n) && inflight_q.size() > 0) begin
        ret_v[i] = inflight_q.pop_front();
      end
      wb_v[i]  = r.wb_arf[i] != '0;
      wbp_v[i] = spec_map[r.wb_arf[i]];
    end
    req      <= r.req;
    retire   <= ret_v;
    wb_valid <= wb_v;
    wb_prf   <= wbp_v;
    stall    <= r.stall;
    recover  <= r.recover;
  endtask

  task automatic check_outputs();
    check_value("allocatable", prf_idx_t'(allocatable),
                prf_idx_t'(free_q.size() >= RENAME_WIDTH));
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      check_value($sformatf("uop_out[%0d].valid", s), prf_idx_t'(uop_out[s].valid),
                  prf_idx_t'(exp_uop[s].valid));
      if (exp_uop[s].valid) begin
        check_value($sformatf("uop_out[%0d].prs1", s), uop_out[s].prs1, exp_uop[s].prs1);
        check_value($sformatf("uop_out[%0d].prs2", s), uop_out[s].prs2, exp_uop[s].prs2);
        check_value($sformatf("uop_out[%0d].rs1_ready", s), prf_idx_t'(uop_out[s].rs1_ready),
                    prf_idx_t'(exp_uop[s].rs1_ready));
        check_value($sformatf("uop_out[%0d].rs2_ready", s), prf_idx_t'(uop_out[s].rs2_ready),
                    prf_idx_t'(exp_uop[s].rs2_ready));
        check_value($sformatf("uop_out[%0d].prev_rd_valid", s),
                    prf_idx_t'(uop_out[s].prev_rd_valid), prf_idx_t'(exp_uop[s].prev_rd_valid));
        if (exp_uop[s].prev_rd_valid) begin
          check_value($sformatf("uop_out[%0d].prd", s), uop_out[s].prd, exp_uop[s].prd);
          check_value($sformatf("uop_out[%0d].prev_rd", s), uop_out[s].prev_rd,
                      exp_uop[s].prev_rd);
        end
      end
    end
    if (pending_prd != '0) begin
      check_value("uop_out[0].prd", uop_out[0].prd, pending_prd);
    end
  endtask

  task automatic model_step();
    renamed_uop_t [RENAME_WIDTH-1:0] nu;
    logic         [PRF_SIZE-1:0]     fresh;
    logic         [PRF_SIZE-1:0]     wb_mask;
    logic                            fire_m;
    retire_t                         rec;
    fire_m  = !stall && !recover && (free_q.size() >= RENAME_WIDTH);
    fresh   = '0;
    wb_mask = '0;
    nu      = '0;
    for (int j = 0; j < COMMIT_WIDTH; j++) begin
      if (wb_valid[j]) begin
        wb_mask[wb_prf[j]] = 1'b1;
      end
    end
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      nu[i].valid     = req[i].valid;
      nu[i].prs1      = spec_map[req[i].rs1];
      nu[i].prs2      = spec_map[req[i].rs2];
      nu[i].rs1_ready = (!busy_m[nu[i].prs1] || wb_mask[nu[i].prs1]) && !fresh[nu[i].prs1];
      nu[i].rs2_ready = (!busy_m[nu[i].prs2] || wb_mask[nu[i].prs2]) && !fresh[nu[i].prs2];
      if (fire_m && req[i].valid && req[i].rd_valid && req[i].rd != '0) begin
        nu[i].prd           = free_q.pop_front();
        nu[i].prev_rd       = spec_map[req[i].rd];
        nu[i].prev_rd_valid = 1'b1;
        rec                 = '{valid: 1'b1, arf: req[i].rd, prf: nu[i].prd,
                                prev_prf: nu[i].prev_rd};
        inflight_q.push_back(rec);
        spec_map[req[i].rd] = nu[i].prd;
        fresh[nu[i].prd]    = 1'b1;
      end
    end
    for (int j = 0; j < COMMIT_WIDTH; j++) begin
      if (retire[j].valid) begin
        commit_map[retire[j].arf] = retire[j].prf;
        free_q.push_back(retire[j].prev_prf);
      end
    end
    busy_m = (busy_m & ~wb_mask) | fresh;
    if (recover) begin
      // Uncommitted allocations return ahead of the free entries
      spec_map = commit_map;
      for (int k = inflight_q.size() - 1; k >= 0; k--) begin
        free_q.push_front(inflight_q[k].prf);
      end
      inflight_q.delete();
      busy_m  = '0;
      exp_uop = '0;
    end else if (!stall) begin
      exp_uop = fire_m ? nu : '0;
    end
  endtask

  initial begin
    int n;
    reset       <= 1'b1;
    stall       <= 1'b0;
    recover     <= 1'b0;
    req         <= '0;
    retire      <= '0;
    wb_valid    <= '0;
    wb_prf      <= '0;
    lfsr_state  = 16'd49134;
    pending_prd = '0;
    exp_uop     = '0;
    busy_m      = '0;
    for (int i = 0; i < ARF_SIZE; i++) begin
      spec_map[i]   = prf_idx_t'(i);
      commit_map[i] = prf_idx_t'(i);
    end
    for (int i = ARF_SIZE; i < PRF_SIZE; i++) begin
      free_q.push_back(prf_idx_t'(i));
    end
    build_table();
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    n = 0;
    @(negedge clock);
    while (!allocatable && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (!allocatable) begin
      $display("Timeout: allocatable stayed low after reset");
      stop_on_error();
    end
    foreach (table_q[r]) begin
      @(posedge clock);
      apply_row(table_q[r]);
      @(negedge clock);
      check_outputs();
      pending_prd = table_q[r].exp_prd;
      model_step();
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: hw/dispatch_stage.sv
/*
  Busy table and output register of the renamed group. Recover clears all
  busy bits. Committed registers are assumed written back before retire.
*/
`timescale 1ns/1ps

module dispatch_stage #(
  parameter int RENAME_WIDTH = 2,
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                                        clock,
  input  logic                                        reset,
  input  logic                                        stall,
  input  logic                                        recover,
  input  rename_pkg::renamed_uop_t [RENAME_WIDTH-1:0] renamed,
  input  logic                                        fire,
  input  logic [COMMIT_WIDTH-1:0]                     wb_valid,
  input  rename_pkg::prf_idx_t [COMMIT_WIDTH-1:0]     wb_prf,
  output rename_pkg::renamed_uop_t [RENAME_WIDTH-1:0] uop_out
);
  import rename_pkg::*;

  logic         [PRF_SIZE-1:0]     busy;
  logic         [PRF_SIZE-1:0]     busy_next;
  renamed_uop_t [RENAME_WIDTH-1:0] staged;

  always_comb begin
    busy_next = busy;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      if (wb_valid[i]) begin
        busy_next[wb_prf[i]] = 1'b0;
      end
    end
    // New destinations win over writeback
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (fire && renamed[i].valid && renamed[i].prev_rd_valid) begin
        busy_next[renamed[i].prd] = 1'b1;
      end
    end
  end

  always_comb begin
    logic hit1;
    logic hit2;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      hit1 = 1'b0;
      hit2 = 1'b0;
      for (int j = 0; j < COMMIT_WIDTH; j++) begin
        hit1 = hit1 | (wb_valid[j] && (wb_prf[j] == renamed[i].prs1));
        hit2 = hit2 | (wb_valid[j] && (wb_prf[j] == renamed[i].prs2));
      end
      staged[i]           = renamed[i];
      staged[i].rs1_ready = !busy[renamed[i].prs1] || hit1;
      staged[i].rs2_ready = !busy[renamed[i].prs2] || hit2;
      // Produced earlier in this same group
      for (int j = 0; j < i; j++) begin
        if (renamed[j].prev_rd_valid && (renamed[j].prd == renamed[i].prs1)) begin
          staged[i].rs1_ready = 1'b0;
        end
        if (renamed[j].prev_rd_valid && (renamed[j].prd == renamed[i].prs2)) begin
          staged[i].rs2_ready = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset || recover) begin
      busy    <= '0;
      uop_out <= '0;
    end else begin
      busy <= busy_next;
      if (!stall) begin
        uop_out <= fire ? staged : '0;
      end
    end
  end

  for (genvar g = 0; g < RENAME_WIDTH; g++) begin : g_busy_chk
    // Destination held in the output register still waits for writeback
    assert property (@(posedge clock) disable iff (reset)
      (uop_out[g].valid && uop_out[g].prev_rd_valid) |-> busy[uop_out[g].prd])
      else $error("slot %0d prd %0h ready at dispatch", g, uop_out[g].prd);
  end

endmodule

// File: hw/free_list.sv
/*
  Ring of free physical registers. Speculative head for allocation, committed
  head for recovery. A valid retire is assumed to carry a real prev_prf.
*/
`timescale 1ns/1ps

module free_list #(
  parameter int RENAME_WIDTH = 2,
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    stall,
  input  logic                                    recover,
  input  logic [RENAME_WIDTH-1:0]                 alloc_req,
  output rename_pkg::prf_idx_t [RENAME_WIDTH-1:0] alloc_prf,
  output logic                                    allocatable,
  input  rename_pkg::retire_t [COMMIT_WIDTH-1:0]  retire
);
  import rename_pkg::*;

  localparam int PTR_W    = $clog2(PRF_SIZE) + 1;
  localparam int NUM_FREE = PRF_SIZE - ARF_SIZE;

  // Extra MSB tells full from empty
  typedef logic [PTR_W-1:0] ptr_t;

  prf_idx_t ring [PRF_SIZE];
  ptr_t     head;
  ptr_t     commit_head;
  ptr_t     tail;
  ptr_t     count;
  ptr_t     alloc_cnt;
  ptr_t     ret_cnt;
  ptr_t     commit_head_next;
  ptr_t     ret_pos [COMMIT_WIDTH];
  logic     accept;

  assign count            = tail - head;
  assign allocatable      = count >= ptr_t'(RENAME_WIDTH);
  assign accept           = !stall && !recover && allocatable;
  assign commit_head_next = commit_head + ret_cnt;

  always_comb begin
    ptr_t slot;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      slot         = head + ptr_t'(i);
      alloc_prf[i] = ring[slot[PTR_W-2:0]];
    end
  end

  always_comb begin
    alloc_cnt = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      alloc_cnt = alloc_cnt + ptr_t'(alloc_req[i]);
    end
    // Freed registers pack densely behind the tail
    ret_cnt = '0;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      ret_pos[i] = tail + ret_cnt;
      ret_cnt    = ret_cnt + ptr_t'(retire[i].valid);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head        <= '0;
      commit_head <= '0;
      tail        <= ptr_t'(NUM_FREE);
      for (int i = 0; i < PRF_SIZE; i++) begin
        ring[i] <= (i < NUM_FREE) ? prf_idx_t'(ARF_SIZE + i) : '0;
      end
    end else begin
      for (int i = 0; i < COMMIT_WIDTH; i++) begin
        if (retire[i].valid) begin
          ring[ret_pos[i][PTR_W-2:0]] <= retire[i].prev_prf;
        end
      end
      tail        <= tail + ret_cnt;
      commit_head <= commit_head_next;
      if (recover) begin
        head <= commit_head_next;
      end else if (accept) begin
        head <= head + alloc_cnt;
      end
    end
  end

  // Never more free entries than non-architectural registers
  assert property (@(posedge clock) disable iff (reset) count <= ptr_t'(NUM_FREE))
    else $error("free list count %0d exceeds %0d", count, NUM_FREE);

endmodule

// File: hw/mapping_table.sv
/*
  Speculative and committed alias tables. Slots rename in order within a
  group. x0 always maps to physical 0 and is never allocated.
*/
`timescale 1ns/1ps

module mapping_table #(
  parameter int RENAME_WIDTH = 2,
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                                        clock,
  input  logic                                        reset,
  input  logic                                        stall,
  input  logic                                        recover,
  input  rename_pkg::rename_req_t [RENAME_WIDTH-1:0]  req,
  input  rename_pkg::retire_t [COMMIT_WIDTH-1:0]      retire,
  output rename_pkg::renamed_uop_t [RENAME_WIDTH-1:0] renamed,
  output logic                                        fire,
  output logic                                        allocatable
);
  import rename_pkg::*;

  prf_idx_t                     spec_map    [ARF_SIZE];
  prf_idx_t                     commit_map  [ARF_SIZE];
  prf_idx_t                     map_work    [ARF_SIZE];
  prf_idx_t                     commit_next [ARF_SIZE];
  logic     [RENAME_WIDTH-1:0]  alloc_req;
  prf_idx_t [RENAME_WIDTH-1:0]  alloc_prf;

  free_list #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_free_list (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .recover     (recover),
    .alloc_req   (alloc_req),
    .alloc_prf   (alloc_prf),
    .allocatable (allocatable),
    .retire      (retire)
  );

  assign fire = !stall && !recover && allocatable;

  // Retirement map, same-cycle retires are visible to recover
  always_comb begin
    commit_next = commit_map;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      if (retire[i].valid) begin
        commit_next[retire[i].arf] = retire[i].prf;
      end
    end
  end

  always_comb begin
    int unsigned k;
    k        = 0;
    map_work = spec_map;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      renamed[i]       = '0;
      renamed[i].valid = req[i].valid;
      // Sources see earlier destinations of the same group
      renamed[i].prs1 = (req[i].rs1 == '0) ? '0 : map_work[req[i].rs1];
      renamed[i].prs2 = (req[i].rs2 == '0) ? '0 : map_work[req[i].rs2];
      alloc_req[i]    = req[i].valid && req[i].rd_valid && (req[i].rd != '0);
      if (alloc_req[i]) begin
        renamed[i].prev_rd       = map_work[req[i].rd];
        renamed[i].prev_rd_valid = 1'b1;
        renamed[i].prd           = alloc_prf[k];
        map_work[req[i].rd]      = alloc_prf[k];
        k                        = k + 1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ARF_SIZE; i++) begin
        spec_map[i]   <= prf_idx_t'(i);
        commit_map[i] <= prf_idx_t'(i);
      end
    end else begin
      commit_map <= commit_next;
      if (recover) begin
        spec_map <= commit_next;
      end else if (fire) begin
        spec_map <= map_work;
      end
    end
  end

  // x0 mapping survives rename, retire and recover
  assert property (@(posedge clock) disable iff (reset)
    (spec_map[0] == '0) && (commit_map[0] == '0))
    else $error("x0 remapped: spec %0h commit %0h", spec_map[0], commit_map[0]);

endmodule

// File: hw/rename_pkg.sv
/*
  Shared types for the rename front end. PRF_SIZE must be a power of two,
  and the ARF_SIZE low physical registers hold the reset mapping.
*/
package rename_pkg;

  parameter int ARF_SIZE = 32;
  parameter int PRF_SIZE = 64;

  typedef logic [$clog2(ARF_SIZE)-1:0] arf_idx_t;
  typedef logic [$clog2(PRF_SIZE)-1:0] prf_idx_t;

  // One instruction entering rename
  typedef struct packed {
    logic     valid;
    arf_idx_t rs1;
    arf_idx_t rs2;
    arf_idx_t rd;
    logic     rd_valid;
  } rename_req_t;

  // One committed destination, prev_prf goes back to the free list
  typedef struct packed {
    logic     valid;
    arf_idx_t arf;
    prf_idx_t prf;
    prf_idx_t prev_prf;
  } retire_t;

  // Renamed instruction, ready bits are filled in by dispatch
  typedef struct packed {
    logic     valid;
    prf_idx_t prs1;
    prf_idx_t prs2;
    prf_idx_t prd;
    prf_idx_t prev_rd;
    logic     prev_rd_valid;
    logic     rs1_ready;
    logic     rs2_ready;
  } renamed_uop_t;

endpackage

// File: hw/rename_unit.sv
/*
  Two-stage rename front end. uop_out follows acceptance by one cycle.
  Retire and writeback act even while stalled.
*/
`timescale 1ns/1ps

module rename_unit #(
  parameter int RENAME_WIDTH = 2,
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                                        clock,
  input  logic                                        reset,
  input  logic                                        stall,
  input  logic                                        recover,
  input  rename_pkg::rename_req_t [RENAME_WIDTH-1:0]  req,
  input  rename_pkg::retire_t [COMMIT_WIDTH-1:0]      retire,
  input  logic [COMMIT_WIDTH-1:0]                     wb_valid,
  input  rename_pkg::prf_idx_t [COMMIT_WIDTH-1:0]     wb_prf,
  output rename_pkg::renamed_uop_t [RENAME_WIDTH-1:0] uop_out,
  output logic                                        allocatable
);
  import rename_pkg::*;

  renamed_uop_t [RENAME_WIDTH-1:0] renamed;
  logic                            fire;

  mapping_table #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_mapping_table (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .recover     (recover),
    .req         (req),
    .retire      (retire),
    .renamed     (renamed),
    .fire        (fire),
    .allocatable (allocatable)
  );

  dispatch_stage #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_dispatch_stage (
    .clock    (clock),
    .reset    (reset),
    .stall    (stall),
    .recover  (recover),
    .renamed  (renamed),
    .fire     (fire),
    .wb_valid (wb_valid),
    .wb_prf   (wb_prf),
    .uop_out  (uop_out)
  );

endmodule

// File: rename_unit.f
hw/rename_pkg.sv
hw/free_list.sv
hw/mapping_table.sv
hw/dispatch_stage.sv
hw/rename_unit.sv
bench/rename_unit_tb.sv
